// File: include/glay_consts.svh
// Datapath widths shared by the GLay vertex kernel RTL
// Include wherever a vertex id, count or result vector is declared

`ifndef GLAY_CONSTS_SVH
`define GLAY_CONSTS_SVH

// Vertex id width
`define GLAY_VERTEX_W 16

// Number of vertices walked in one run
`define GLAY_COUNT_W 16

// Reduced result returned to the host
`define GLAY_RESULT_W 32

`endif

// File: hw/glay_pkg.sv
// Shared types for the GLay vertex kernel
// Control FSM states and reduce opcodes

package glay_pkg;

    // Kernel control FSM states for host handshake sequencing
    typedef enum logic [2:0] {
        CTRL_RESET = 3'd0,
        CTRL_IDLE  = 3'd1,
        CTRL_SETUP = 3'd2,
        CTRL_READY = 3'd3,
        CTRL_START = 3'd4,
        CTRL_BUSY  = 3'd5,
        CTRL_DONE  = 3'd6
    } ctrl_state_t;

    // Reduction applied over the walked vertex ids
    typedef enum logic [1:0] {
        REDUCE_SUM = 2'd0,
        REDUCE_MAX = 2'd1,
        REDUCE_XOR = 2'd2
    } reduce_op_t;

endpackage : glay_pkg

// File: hw/kernel_control.sv
// Kernel control FSM for the host handshake (ap_start, ap_ready, ap_idle, ap_done)
// Sequences setup wait, one run strobe and completion for the vertex datapath

module kernel_control (
    input  logic ap_clk,
    input  logic control_areset,
    input  logic ap_start,
    input  logic desc_pending,
    input  logic cu_done,
    output logic ap_ready,
    output logic ap_idle,
    output logic ap_done,
    output logic run_start
);

    import glay_pkg::*;

    logic reset_reg;
    logic ap_start_reg;
    logic cu_done_reg;

    ctrl_state_t state;
    ctrl_state_t next_state;

    // State decode and the first output stage
    logic dec_ready;
    logic dec_idle;
    logic dec_done;
    logic stg_ready;
    logic stg_idle;
    logic stg_done;

    // --------------------------------------------------------------------------
    // Input registers
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        reset_reg <= control_areset;
    end

    always_ff @(posedge ap_clk) begin
        if (reset_reg) begin
            ap_start_reg <= 1'b0;
            cu_done_reg  <= 1'b0;
        end else begin
            ap_start_reg <= ap_start;
            cu_done_reg  <= cu_done;
        end
    end

    // --------------------------------------------------------------------------
    // Handshake FSM
    // --------------------------------------------------------------------------
    always_ff @(posedge ap_clk) begin
        if (reset_reg) begin
            state <= CTRL_RESET;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            CTRL_RESET: next_state = CTRL_IDLE;
            CTRL_IDLE:  next_state = CTRL_SETUP;
            CTRL_SETUP: begin
                if (ap_start_reg) next_state = CTRL_READY;
            end
            // Descriptor must be in place before the run is launched
            CTRL_READY: begin
                if (desc_pending) next_state = CTRL_START;
            end
            CTRL_START: next_state = CTRL_BUSY;
            CTRL_BUSY: begin
                if (cu_done_reg) next_state = CTRL_DONE;
            end
            // Chained run goes straight back to READY
            CTRL_DONE: begin
                if (ap_start_reg) next_state = CTRL_READY;
            end
            default: next_state = CTRL_RESET;
        endcase
    end

    // One run strobe per pass through START
    assign run_start = (state == CTRL_START);

    // --------------------------------------------------------------------------
    // Output decode and two register stages
    // --------------------------------------------------------------------------
    always_comb begin
        dec_ready = 1'b0;
        dec_idle  = 1'b0;
        dec_done  = 1'b0;
        case (state)
            CTRL_RESET, CTRL_IDLE, CTRL_SETUP: dec_idle = 1'b1;
            CTRL_READY: dec_ready = 1'b1;
            CTRL_DONE: begin
                dec_done = 1'b1;
                dec_idle = 1'b1;
            end
            default: dec_idle = 1'b0;
        endcase
    end

    always_ff @(posedge ap_clk) begin
        if (reset_reg) begin
            stg_ready <= 1'b0;
            stg_idle  <= 1'b1;
            stg_done  <= 1'b0;
        end else begin
            stg_ready <= dec_ready;
            stg_idle  <= dec_idle;
            stg_done  <= dec_done;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (reset_reg) begin
            ap_ready <= 1'b0;
            ap_idle  <= 1'b1;
            ap_done  <= 1'b0;
        end else begin
            ap_ready <= stg_ready;
            ap_idle  <= stg_idle;
            ap_done  <= stg_done;
        end
    end

endmodule : kernel_control

// File: hw/descriptor_latch.sv
// Holds the host descriptor for the next run
// Pending flag is raised by desc_strobe and consumed by run_start

`include "glay_consts.svh"

module descriptor_latch (
    input  logic                       ap_clk,
    input  logic                       control_areset,
    input  logic                       desc_strobe,
    input  logic                       run_start,
    input  logic [`GLAY_VERTEX_W-1:0]  desc_start_vertex,
    input  logic [`GLAY_COUNT_W-1:0]   desc_vertex_count,
    input  glay_pkg::reduce_op_t       desc_op,
    output logic [`GLAY_VERTEX_W-1:0]  start_vertex,
    output logic [`GLAY_COUNT_W-1:0]   vertex_count,
    output glay_pkg::reduce_op_t       op,
    output logic                       desc_pending
);

    // Descriptor fields
    always_ff @(posedge ap_clk) begin
        if (desc_strobe) begin
            start_vertex <= desc_start_vertex;
            vertex_count <= desc_vertex_count;
            op           <= desc_op;
        end
    end

    // A strobe in the run_start cycle belongs to the next run
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            desc_pending <= 1'b0;
        end else if (desc_strobe) begin
            desc_pending <= 1'b1;
        end else if (run_start) begin
            desc_pending <= 1'b0;
        end
    end

endmodule : descriptor_latch

// File: hw/vertex_walker.sv
// Walks vertex ids from start_vertex over vertex_count entries, one per cycle
// walk_end marks the last id, or comes alone for an empty range

`include "glay_consts.svh"

module vertex_walker (
    input  logic                       ap_clk,
    input  logic                       control_areset,
    input  logic                       run_start,
    input  logic [`GLAY_VERTEX_W-1:0]  start_vertex,
    input  logic [`GLAY_COUNT_W-1:0]   vertex_count,
    output logic                       vertex_strobe,
    output logic                       walk_end,
    output logic [`GLAY_VERTEX_W-1:0]  vertex_id
);

    // Ids still to emit after the current one
    logic [`GLAY_COUNT_W-1:0] remaining;

    // Control state
    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            remaining     <= '0;
            vertex_strobe <= 1'b0;
            walk_end      <= 1'b0;
        end else if (run_start) begin
            // Empty range ends without any id
            if (vertex_count == '0) begin
                remaining     <= '0;
                vertex_strobe <= 1'b0;
                walk_end      <= 1'b1;
            end else begin
                remaining     <= vertex_count - 1'b1;
                vertex_strobe <= 1'b1;
                walk_end      <= (vertex_count == `GLAY_COUNT_W'd1);
            end
        end else if (remaining != '0) begin
            remaining     <= remaining - 1'b1;
            vertex_strobe <= 1'b1;
            walk_end      <= (remaining == `GLAY_COUNT_W'd1);
        end else begin
            vertex_strobe <= 1'b0;
            walk_end      <= 1'b0;
        end
    end

    // Id register
    always_ff @(posedge ap_clk) begin
        if (run_start) begin
            vertex_id <= start_vertex;
        end else if (remaining != '0) begin
            vertex_id <= vertex_id + 1'b1;
        end
    end

endmodule : vertex_walker

// File: hw/vertex_reduce.sv
// Folds the walked vertex ids with SUM, MAX or XOR
// Publishes result and a cu_done pulse one cycle after walk_end

`include "glay_consts.svh"

module vertex_reduce (
    input  logic                       ap_clk,
    input  logic                       control_areset,
    input  logic                       run_start,
    input  logic                       vertex_strobe,
    input  logic                       walk_end,
    input  logic [`GLAY_VERTEX_W-1:0]  vertex_id,
    input  glay_pkg::reduce_op_t       op,
    output logic [`GLAY_RESULT_W-1:0]  result,
    output logic                       cu_done
);

    import glay_pkg::*;

    reduce_op_t               op_reg;
    logic [`GLAY_RESULT_W-1:0] acc;
    logic [`GLAY_RESULT_W-1:0] acc_next;

    // One reduction step
    // Zero is the identity for all three ops
    function automatic logic [`GLAY_RESULT_W-1:0] fold(
        input reduce_op_t                fop,
        input logic [`GLAY_RESULT_W-1:0] a,
        input logic [`GLAY_VERTEX_W-1:0] id
    );
        logic [`GLAY_RESULT_W-1:0] v;
        v = `GLAY_RESULT_W'(id);
        case (fop)
            REDUCE_SUM: fold = a + v;
            REDUCE_MAX: fold = (v > a) ? v : a;
            REDUCE_XOR: fold = a ^ v;
            default:    fold = a;
        endcase
    endfunction

    // The last id arrives together with walk_end
    assign acc_next = vertex_strobe ? fold(op_reg, acc, vertex_id) : acc;

    always_ff @(posedge ap_clk) begin
        if (run_start) begin
            op_reg <= op;
            acc    <= '0;
        end else begin
            acc <= acc_next;
        end
        if (walk_end) begin
            result <= acc_next;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (control_areset) begin
            cu_done <= 1'b0;
        end else begin
            cu_done <= walk_end;
        end
    end

endmodule : vertex_reduce

// File: hw/glay_kernel.sv
// Top level of the GLay vertex kernel
// Connects the handshake FSM to the descriptor latch, walker and reduce stage

`include "glay_consts.svh"

module glay_kernel (
    input  logic                       ap_clk,
    input  logic                       control_areset,
    input  logic                       ap_start,
    input  logic                       desc_strobe,
    input  logic [`GLAY_VERTEX_W-1:0]  desc_start_vertex,
    input  logic [`GLAY_COUNT_W-1:0]   desc_vertex_count,
    input  glay_pkg::reduce_op_t       desc_op,
    output logic                       ap_ready,
    output logic                       ap_idle,
    output logic                       ap_done,
    output logic [`GLAY_RESULT_W-1:0]  result
);

    import glay_pkg::*;

    // Control strobes
    logic desc_pending;
    logic run_start;
    logic cu_done;

    // Latched descriptor
    logic [`GLAY_VERTEX_W-1:0] start_vertex;
    logic [`GLAY_COUNT_W-1:0]  vertex_count;
    reduce_op_t                op;

    // Walker to reduce
    logic                      vertex_strobe;
    logic                      walk_end;
    logic [`GLAY_VERTEX_W-1:0] vertex_id;

    kernel_control u_kernel_control (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .ap_start       (ap_start),
        .desc_pending   (desc_pending),
        .cu_done        (cu_done),
        .ap_ready       (ap_ready),
        .ap_idle        (ap_idle),
        .ap_done        (ap_done),
        .run_start      (run_start)
    );

    descriptor_latch u_descriptor_latch (
        .ap_clk            (ap_clk),
        .control_areset    (control_areset),
        .desc_strobe       (desc_strobe),
        .run_start         (run_start),
        .desc_start_vertex (desc_start_vertex),
        .desc_vertex_count (desc_vertex_count),
        .desc_op           (desc_op),
        .start_vertex      (start_vertex),
        .vertex_count      (vertex_count),
        .op                (op),
        .desc_pending      (desc_pending)
    );

    vertex_walker u_vertex_walker (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .run_start      (run_start),
        .start_vertex   (start_vertex),
        .vertex_count   (vertex_count),
        .vertex_strobe  (vertex_strobe),
        .walk_end       (walk_end),
        .vertex_id      (vertex_id)
    );

    vertex_reduce u_vertex_reduce (
        .ap_clk         (ap_clk),
        .control_areset (control_areset),
        .run_start      (run_start),
        .vertex_strobe  (vertex_strobe),
        .walk_end       (walk_end),
        .vertex_id      (vertex_id),
        .op             (op),
        .result         (result),
        .cu_done        (cu_done)
    );

endmodule : glay_kernel

// File: verif/glay_kernel_checker.sv
// Concurrent handshake assertions for kernel_control
// Attached to every kernel_control instance by the bind at the end

module glay_kernel_checker (
    input logic                  ap_clk,
    input logic                  control_areset,
    input glay_pkg::ctrl_state_t state,
    input logic                  ap_ready,
    input logic                  ap_idle,
    input logic                  ap_done,
    input logic                  run_start,
    input logic                  desc_pending,
    input logic                  cu_done
);

    timeunit 1ns;
    timeprecision 1ps;

    import glay_pkg::*;

    // Failure count shown in the testbench summary
    int assert_failures = 0;

    ready_done_exclusive: assert property (
        @(posedge ap_clk) disable iff (control_areset) !(ap_ready && ap_done)
    ) else begin
        assert_failures++;
        $error("ap_ready and ap_done are high in the same cycle");
    end

    // Idle drops through both output stages once a run launches
    run_clears_idle: assert property (
        @(posedge ap_clk) disable iff (control_areset) run_start |-> ##2 !ap_idle
    ) else begin
        assert_failures++;
        $error("ap_idle is still high two cycles after run_start");
    end

    // Descriptor must be waiting when a run launches
    run_start_has_desc: assert property (
        @(posedge ap_clk) disable iff (control_areset) run_start |-> desc_pending
    ) else begin
        assert_failures++;
        $error("run_start fired with no descriptor pending");
    end

    cu_done_in_busy: assert property (
        @(posedge ap_clk) disable iff (control_areset) cu_done |-> state == CTRL_BUSY
    ) else begin
        assert_failures++;
        $error("cu_done seen outside the BUSY state");
    end

endmodule : glay_kernel_checker

bind kernel_control glay_kernel_checker u_checker (
    .ap_clk         (ap_clk),
    .control_areset (control_areset),
    .state          (state),
    .ap_ready       (ap_ready),
    .ap_idle        (ap_idle),
    .ap_done        (ap_done),
    .run_start      (run_start),
    .desc_pending   (desc_pending),
    .cu_done        (cu_done)
);

// File: verif/glay_kernel_tb.sv
// Testbench for the GLay vertex kernel
// Loads descriptors from the tests file, drives the host handshake and
// compares each result with the file's expected column

`include "glay_consts.svh"

module glay_kernel_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import glay_pkg::*;

    localparam time   CLK_PERIOD   = 100ns;
    localparam time   DRIVE_DELAY  = 5ns;
    localparam int    RESET_CYCLES = 4;
    localparam int    RAND_SEED    = 46086;
    localparam int    MAX_GAP      = 5;
    localparam string TEST_FILE    = "verif/glay_kernel_tests.txt";

    logic                      ap_clk = 1'b0;
    logic                      control_areset;
    logic                      ap_start;
    logic                      desc_strobe;
    logic [`GLAY_VERTEX_W-1:0] desc_start_vertex;
    logic [`GLAY_COUNT_W-1:0]  desc_vertex_count;
    reduce_op_t                desc_op;
    logic                      ap_ready;
    logic                      ap_idle;
    logic                      ap_done;
    logic [`GLAY_RESULT_W-1:0] result;

    // Test table with one entry per data line
    string                     test_name[$];
    logic [`GLAY_VERTEX_W-1:0] test_start[$];
    logic [`GLAY_COUNT_W-1:0]  test_count[$];
    reduce_op_t                test_op[$];
    logic [`GLAY_RESULT_W-1:0] test_expect[$];

    int errors       = 0;
    int checks       = 0;
    bit tests_loaded = 1'b0;

    glay_kernel uut (
        .ap_clk            (ap_clk),
        .control_areset    (control_areset),
        .ap_start          (ap_start),
        .desc_strobe       (desc_strobe),
        .desc_start_vertex (desc_start_vertex),
        .desc_vertex_count (desc_vertex_count),
        .desc_op           (desc_op),
        .ap_ready          (ap_ready),
        .ap_idle           (ap_idle),
        .ap_done           (ap_done),
        .result            (result)
    );

    always #(CLK_PERIOD / 2) ap_clk = ~ap_clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAILED %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    // Outputs are settled and inputs may change here
    task automatic next_drive_point();
        @(posedge ap_clk);
        #DRIVE_DELAY;
    endtask

    function automatic bit decode_op(input string text, output reduce_op_t op);
        decode_op = 1'b1;
        op        = REDUCE_SUM;
        if (text == "SUM") op = REDUCE_SUM;
        else if (text == "MAX") op = REDUCE_MAX;
        else if (text == "XOR") op = REDUCE_XOR;
        else decode_op = 1'b0;
    endfunction

    task automatic read_tests();
        int                        fd;
        int                        fields;
        bit                        op_ok;
        string                     line;
        string                     name;
        string                     op_text;
        logic [`GLAY_VERTEX_W-1:0] start;
        logic [`GLAY_COUNT_W-1:0]  count;
        logic [`GLAY_RESULT_W-1:0] expected;
        reduce_op_t                op;
        fd = $fopen(TEST_FILE, "r");
        if (fd == 0) begin
            errors++;
            $display("ERROR: cannot open test file %s", TEST_FILE);
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            // Blank and comment lines
            if (line.len() < 2 || line.getc(0) == "#") continue;
            fields = $sscanf(line, "%s %h %h %s %h", name, start, count, op_text, expected);
            op_ok  = decode_op(op_text, op);
            if (fields != 5 || !op_ok) begin
                errors++;
                $display("ERROR: malformed line in test file: %s", line);
            end else begin
                test_name.push_back(name);
                test_start.push_back(start);
                test_count.push_back(count);
                test_op.push_back(op);
                test_expect.push_back(expected);
            end
        end
        $fclose(fd);
        if (test_name.size() == 0) begin
            errors++;
            $display("ERROR: no tests found in %s", TEST_FILE);
        end
    endtask

    task automatic strobe_descriptor(input int idx);
        desc_start_vertex = test_start[idx];
        desc_vertex_count = test_count[idx];
        desc_op           = test_op[idx];
        desc_strobe       = 1'b1;
        next_drive_point();
        desc_strobe       = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // One host run
    // ------------------------------------------------------------------------
    task automatic run_test(input int idx, input bit loaded, output bit next_loaded);
        next_loaded = 1'b0;
        if (!loaded) begin
            strobe_descriptor(idx);
        end
        ap_start = 1'b1;
        do begin
            next_drive_point();
        end while (ap_ready !== 1'b1);
        ap_start = 1'b0;
        // Odd runs hand over the next descriptor while still busy
        if (idx % 2 == 1 && idx + 1 < test_name.size()) begin
            strobe_descriptor(idx + 1);
            next_loaded = 1'b1;
        end
        while (ap_done !== 1'b1) begin
            next_drive_point();
        end
        check_value(test_name[idx], test_expect[idx], result);
    endtask

    // Done, idle and result hold until the next ap_start
    task automatic hold_between_runs(input int idx);
        int gap;
        gap = $urandom_range(MAX_GAP, 0);
        repeat (gap) begin
            next_drive_point();
            check_value({test_name[idx], " ap_done held"}, 32'd1, 32'(ap_done));
            check_value({test_name[idx], " ap_idle held"}, 32'd1, 32'(ap_idle));
            check_value({test_name[idx], " result held"}, test_expect[idx], result);
        end
    endtask

    initial begin : main
        bit loaded;
        bit next_loaded;
        control_areset    = 1'b1;
        ap_start          = 1'b0;
        desc_strobe       = 1'b0;
        desc_start_vertex = '0;
        desc_vertex_count = '0;
        desc_op           = REDUCE_SUM;
        void'($urandom(RAND_SEED));
        read_tests();
        tests_loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge ap_clk);
        #DRIVE_DELAY;
        control_areset = 1'b0;

        // Quiet handshake before any start
        repeat (3) begin
            next_drive_point();
            check_value("after_reset ap_idle", 32'd1, 32'(ap_idle));
            check_value("after_reset ap_ready", 32'd0, 32'(ap_ready));
            check_value("after_reset ap_done", 32'd0, 32'(ap_done));
        end

        loaded = 1'b0;
        foreach (test_name[i]) begin
            run_test(i, loaded, next_loaded);
            loaded = next_loaded;
            hold_between_runs(i);
        end

        $display("Summary: %0d checks, %0d errors, %0d assertion failures",
                 checks, errors, uut.u_kernel_control.u_checker.assert_failures);
        if (errors == 0 && uut.u_kernel_control.u_checker.assert_failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin : watchdog
        int limit;
        wait (tests_loaded);
        limit = RESET_CYCLES + 10;
        foreach (test_count[i]) begin
            limit += int'(test_count[i]) + 40;
        end
        repeat (limit) @(posedge ap_clk);
        $display("Timeout: the tests did not finish within %0d clock cycles", limit);
        $display("sim failed");
        $finish;
    end

endmodule : glay_kernel_tb

// File: verif/glay_kernel_tests.txt
# name  start(hex)  count(hex)  op(SUM|MAX|XOR)  expected(hex)
# sum_id_wrap runs the 16-bit vertex id past 0xffff back to 0
sum_small     0000  000a  SUM  0000002d
sum_offset    0064  0032  SUM  00001851
sum_large     f000  1000  SUM  0f7ff800
sum_id_wrap   fffe  0004  SUM  0001fffe
max_small     0005  0007  MAX  0000000b
max_high      1234  0100  MAX  00001333
xor_first6    0000  0006  XOR  00000001
xor_3_to_7    0003  0005  XOR  00000003
xor_short     0010  0003  XOR  00000013
sum_empty     0055  0000  SUM  00000000
max_empty     0077  0000  MAX  00000000
xor_empty     0099  0000  XOR  00000000
sum_single    4000  0001  SUM  00004000

// File: all.f
+incdir+include
hw/glay_pkg.sv
hw/kernel_control.sv
hw/descriptor_latch.sv
hw/vertex_walker.sv
hw/vertex_reduce.sv
hw/glay_kernel.sv
verif/glay_kernel_checker.sv
verif/glay_kernel_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the GLay kernel testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ps \
    --top-module glay_kernel_tb -f all.f > build.log 2>&1 \
    || { cat build.log; echo "Verilator build failed"; exit 1; }

./obj_dir/Vglay_kernel_tb +verilator+error+limit+100 > sim.log 2>&1 \
    || { cat sim.log; echo "Simulation exited abnormally"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
